// ==== common/corebus_pkg.sv ====
// shared field widths and command codes for the write-packing bus stage
// imported by every packer block and by the testbench
package corebus_pkg;

  // command kind field
  localparam int CMD_W = 2;

  // request address
  localparam int ADDR_W = 32;

  // write data beat
  localparam int DATA_W = 32;

  // burst length field, holds beats minus one
  localparam int LEN_W = 4;

  // command kinds, only writes carry data beats
  localparam logic [CMD_W-1:0] CMD_READ  = 2'd0;
  localparam logic [CMD_W-1:0] CMD_WRITE = 2'd1;
  localparam logic [CMD_W-1:0] CMD_FLUSH = 2'd2;

  // longest burst in beats, one full length field
  localparam int MAX_BURST = 1 << LEN_W;

endpackage

// ==== logic/command_fifo.sv ====
// show-ahead FIFO for command kind, address and length
// head entry is valid one cycle after its push, pop takes it in the same cycle
`timescale 1ns/1ps
module command_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear,
  input  logic                           i_push,
  input  logic [corebus_pkg::CMD_W-1:0]  i_cmd,
  input  logic [corebus_pkg::ADDR_W-1:0] i_addr,
  input  logic [corebus_pkg::LEN_W-1:0]  i_len,
  input  logic                           i_pop,
  output logic                           o_valid,
  output logic [corebus_pkg::CMD_W-1:0]  o_cmd,
  output logic [corebus_pkg::ADDR_W-1:0] o_addr,
  output logic [corebus_pkg::LEN_W-1:0]  o_len,
  output logic                           o_empty,
  output logic                           o_full
);
  import corebus_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [CMD_W-1:0]  cmd_mem  [DEPTH];
  logic [ADDR_W-1:0] addr_mem [DEPTH];
  logic [LEN_W-1:0]  len_mem  [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push_en;
  logic              pop_en;

  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_valid = !o_empty;
  assign push_en = i_push && !o_full; // drop pushes into a full queue
  assign pop_en  = i_pop && o_valid;

  assign o_cmd  = cmd_mem[rd_ptr]; // head shown without a read cycle
  assign o_addr = addr_mem[rd_ptr];
  assign o_len  = len_mem[rd_ptr];

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1); // wrap at depth
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count; // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_en) begin
      cmd_mem[wr_ptr]  <= i_cmd;
      addr_mem[wr_ptr] <= i_addr;
      len_mem[wr_ptr]  <= i_len;
    end
  end

endmodule

// ==== logic/write_data_fifo.sv ====
// show-ahead FIFO for write data beats and their last flags
// o_full holds back the input once DEPTH beats are stored
`timescale 1ns/1ps
module write_data_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear,
  input  logic                           i_push,
  input  logic [corebus_pkg::DATA_W-1:0] i_data,
  input  logic                           i_last,
  input  logic                           i_pop,
  output logic                           o_valid,
  output logic [corebus_pkg::DATA_W-1:0] o_data,
  output logic                           o_last,
  output logic                           o_empty,
  output logic                           o_full
);
  import corebus_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] data_mem [DEPTH];
  logic              last_mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push_en;
  logic              pop_en;

  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_valid = !o_empty;
  assign push_en = i_push && !o_full;
  assign pop_en  = i_pop && o_valid; // pops on an empty queue are ignored

  assign o_data = data_mem[rd_ptr];
  assign o_last = last_mem[rd_ptr];

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // beat storage
  always_ff @(posedge i_clk) begin
    if (push_en) begin
      data_mem[wr_ptr] <= i_data;
      last_mem[wr_ptr] <= i_last;
    end
  end

endmodule

// ==== logic/request_slicer.sv ====
// two-entry skid register on the command and data channels toward the master
// outputs come from flops, input accepts depend only on each channel's fill level
`timescale 1ns/1ps
module request_slicer (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_cmd_valid,
  input  logic [corebus_pkg::CMD_W-1:0]  i_cmd,
  input  logic [corebus_pkg::ADDR_W-1:0] i_addr,
  input  logic [corebus_pkg::LEN_W-1:0]  i_len,
  input  logic                           i_data_valid,
  input  logic [corebus_pkg::DATA_W-1:0] i_data,
  input  logic                           i_data_last,
  input  logic                           i_cmd_accept,
  input  logic                           i_data_accept,
  output logic                           o_cmd_accept,
  output logic                           o_data_accept,
  output logic                           o_cmd_valid,
  output logic [corebus_pkg::CMD_W-1:0]  o_cmd,
  output logic [corebus_pkg::ADDR_W-1:0] o_addr,
  output logic [corebus_pkg::LEN_W-1:0]  o_len,
  output logic                           o_data_valid,
  output logic [corebus_pkg::DATA_W-1:0] o_data,
  output logic                           o_data_last
);
  import corebus_pkg::*;

  localparam int CMD_PAY_W  = CMD_W + ADDR_W + LEN_W;
  localparam int DATA_PAY_W = DATA_W + 1;
  localparam int PAY_W      = (CMD_PAY_W > DATA_PAY_W) ? CMD_PAY_W : DATA_PAY_W;

  // channel 0 is the command, channel 1 the write data
  logic [1:0]       in_valid;
  logic [1:0]       in_accept;
  logic [1:0]       out_valid;
  logic [1:0]       out_accept;
  logic [PAY_W-1:0] in_pay  [2];
  logic [PAY_W-1:0] out_pay [2];

  assign in_valid   = {i_data_valid, i_cmd_valid};
  assign out_accept = {i_data_accept, i_cmd_accept};
  assign in_pay[0]  = PAY_W'({i_cmd, i_addr, i_len});
  assign in_pay[1]  = PAY_W'({i_data, i_data_last}); // zero padded

  for (genvar ch = 0; ch < 2; ch++) begin : g_channel
    logic [PAY_W-1:0] entry [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic             push;
    logic             pop;

    assign in_accept[ch] = (count != 2'd2); // room for one more beat
    assign out_valid[ch] = (count != 2'd0);
    assign out_pay[ch]   = entry[rd_ptr];
    assign push          = in_valid[ch] && in_accept[ch];
    assign pop           = out_valid[ch] && out_accept[ch];

    always_ff @(posedge i_clk, negedge i_rst_n) begin
      if (!i_rst_n) begin
        wr_ptr <= 1'b0;
        rd_ptr <= 1'b0;
        count  <= 2'd0;
      end else begin
        if (push) begin
          wr_ptr <= !wr_ptr;
        end
        if (pop) begin
          rd_ptr <= !rd_ptr;
        end
        count <= count + 2'(push) - 2'(pop); // steady state sits at one entry
      end
    end

    always_ff @(posedge i_clk) begin
      if (push) begin
        entry[wr_ptr] <= in_pay[ch];
      end
    end
  end

  assign o_cmd_accept  = in_accept[0];
  assign o_data_accept = in_accept[1];
  assign o_cmd_valid   = out_valid[0];
  assign o_data_valid  = out_valid[1];

  assign {o_cmd, o_addr, o_len}  = out_pay[0][CMD_PAY_W-1:0];
  assign {o_data, o_data_last}   = out_pay[1][DATA_PAY_W-1:0];

endmodule

// ==== packer/packer_control.sv ====
// release control between the FIFO heads and the output slicer
// a write leaves only once all its beats are stored, reads and flushes pass at once
`timescale 1ns/1ps
module packer_control #(
  parameter int COMMAND_DEPTH = 4
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_clear,
  input  logic                          i_in_last_ack,
  input  logic                          i_cmd_valid,
  input  logic [corebus_pkg::CMD_W-1:0] i_cmd,
  input  logic                          i_data_valid,
  input  logic                          i_data_last,
  input  logic                          i_out_cmd_accept,
  input  logic                          i_out_data_accept,
  output logic                          o_cmd_pop,
  output logic                          o_data_pop,
  output logic                          o_out_cmd_valid,
  output logic                          o_out_data_valid
);
  import corebus_pkg::*;

  // data may run ahead of its commands by a full data FIFO of short packets
  localparam int COUNT_W = $clog2(COMMAND_DEPTH + MAX_BURST + 1);

  logic [COUNT_W-1:0] packet_count;
  logic               cmd_sent;
  logic               data_sent;
  logic               head_write;
  logic               write_ready;
  logic               cmd_ack;
  logic               last_ack;
  logic               write_done;

  assign head_write = i_cmd_valid && (i_cmd == CMD_WRITE);

  // after the command leaves, the head shows the next command, so cmd_sent keeps the write
  assign write_ready = (cmd_sent || head_write) &&
                       ((packet_count != '0) || data_sent);

  always_comb begin
    if (write_ready) begin
      o_out_cmd_valid  = !cmd_sent && i_cmd_valid;
      o_out_data_valid = !data_sent && i_data_valid;
    end else if (i_cmd_valid && !head_write) begin
      o_out_cmd_valid  = 1'b1; // read or flush
      o_out_data_valid = 1'b0;
    end else begin
      o_out_cmd_valid  = 1'b0; // write still collecting beats
      o_out_data_valid = 1'b0;
    end
  end

  assign o_cmd_pop  = o_out_cmd_valid && i_out_cmd_accept;
  assign o_data_pop = o_out_data_valid && i_out_data_accept;

  assign cmd_ack    = o_cmd_pop && head_write;
  assign last_ack   = o_data_pop && i_data_last;
  assign write_done = (cmd_ack && last_ack) ||
                      (cmd_ack && data_sent) ||
                      (cmd_sent && last_ack);

  // complete packets waiting in the data FIFO
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      packet_count <= '0;
    end else if (i_clear) begin
      packet_count <= '0;
    end else if (i_in_last_ack && !last_ack) begin
      packet_count <= packet_count + COUNT_W'(1);
    end else if (!i_in_last_ack && last_ack) begin
      packet_count <= packet_count - COUNT_W'(1);
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_sent  <= 1'b0;
      data_sent <= 1'b0;
    end else if (i_clear || write_done) begin
      cmd_sent  <= 1'b0;
      data_sent <= 1'b0;
    end else begin
      if (cmd_ack) begin
        cmd_sent <= 1'b1;
      end
      if (last_ack) begin
        data_sent <= 1'b1;
      end
    end
  end

endmodule

// ==== packer/corebus_packer.sv ====
// write-packing stage, buffers commands and write data and releases complete writes
// set COMMAND_DEPTH and DATA_DEPTH here, they are passed down to the FIFOs and control
`timescale 1ns/1ps
module corebus_packer #(
  parameter int COMMAND_DEPTH = 4,
  parameter int DATA_DEPTH    = corebus_pkg::MAX_BURST
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_clear,
  output logic [1:0]                     o_fifo_empty,
  output logic [1:0]                     o_fifo_full,
  input  logic                           i_mcmd_valid,
  input  logic [corebus_pkg::CMD_W-1:0]  i_mcmd,
  input  logic [corebus_pkg::ADDR_W-1:0] i_maddr,
  input  logic [corebus_pkg::LEN_W-1:0]  i_mlength,
  output logic                           o_scmd_accept,
  input  logic                           i_mdata_valid,
  input  logic [corebus_pkg::DATA_W-1:0] i_mdata,
  input  logic                           i_mdata_last,
  output logic                           o_sdata_accept,
  output logic                           o_mcmd_valid,
  output logic [corebus_pkg::CMD_W-1:0]  o_mcmd,
  output logic [corebus_pkg::ADDR_W-1:0] o_maddr,
  output logic [corebus_pkg::LEN_W-1:0]  o_mlength,
  input  logic                           i_scmd_accept,
  output logic                           o_mdata_valid,
  output logic [corebus_pkg::DATA_W-1:0] o_mdata,
  output logic                           o_mdata_last,
  input  logic                           i_sdata_accept
);
  import corebus_pkg::*;

  logic              cmd_push;
  logic              data_push;
  logic              in_last_ack;
  logic              cmd_head_valid;
  logic [CMD_W-1:0]  cmd_head;
  logic [ADDR_W-1:0] addr_head;
  logic [LEN_W-1:0]  len_head;
  logic              data_head_valid;
  logic [DATA_W-1:0] data_head;
  logic              data_head_last;
  logic              cmd_pop;
  logic              data_pop;
  logic              slice_cmd_valid;
  logic              slice_data_valid;
  logic              slice_cmd_accept;
  logic              slice_data_accept;

  assign o_scmd_accept  = !o_fifo_full[0];
  assign o_sdata_accept = !o_fifo_full[1];
  assign cmd_push       = i_mcmd_valid && o_scmd_accept;
  assign data_push      = i_mdata_valid && o_sdata_accept;
  assign in_last_ack    = data_push && i_mdata_last; // one packet fully stored

  command_fifo #(
    .DEPTH (COMMAND_DEPTH)
  ) u_command_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_clear (i_clear),
    .i_push  (cmd_push),
    .i_cmd   (i_mcmd),
    .i_addr  (i_maddr),
    .i_len   (i_mlength),
    .i_pop   (cmd_pop),
    .o_valid (cmd_head_valid),
    .o_cmd   (cmd_head),
    .o_addr  (addr_head),
    .o_len   (len_head),
    .o_empty (o_fifo_empty[0]),
    .o_full  (o_fifo_full[0])
  );

  write_data_fifo #(
    .DEPTH (DATA_DEPTH)
  ) u_write_data_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_clear (i_clear),
    .i_push  (data_push),
    .i_data  (i_mdata),
    .i_last  (i_mdata_last),
    .i_pop   (data_pop),
    .o_valid (data_head_valid),
    .o_data  (data_head),
    .o_last  (data_head_last),
    .o_empty (o_fifo_empty[1]),
    .o_full  (o_fifo_full[1])
  );

  packer_control #(
    .COMMAND_DEPTH (COMMAND_DEPTH)
  ) u_packer_control (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_clear           (i_clear),
    .i_in_last_ack     (in_last_ack),
    .i_cmd_valid       (cmd_head_valid),
    .i_cmd             (cmd_head),
    .i_data_valid      (data_head_valid),
    .i_data_last       (data_head_last),
    .i_out_cmd_accept  (slice_cmd_accept),
    .i_out_data_accept (slice_data_accept),
    .o_cmd_pop         (cmd_pop),
    .o_data_pop        (data_pop),
    .o_out_cmd_valid   (slice_cmd_valid),
    .o_out_data_valid  (slice_data_valid)
  );

  request_slicer u_request_slicer (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_valid   (slice_cmd_valid),
    .i_cmd         (cmd_head),
    .i_addr        (addr_head),
    .i_len         (len_head),
    .i_data_valid  (slice_data_valid),
    .i_data        (data_head),
    .i_data_last   (data_head_last),
    .i_cmd_accept  (i_scmd_accept),
    .i_data_accept (i_sdata_accept),
    .o_cmd_accept  (slice_cmd_accept),
    .o_data_accept (slice_data_accept),
    .o_cmd_valid   (o_mcmd_valid),
    .o_cmd         (o_mcmd),
    .o_addr        (o_maddr),
    .o_len         (o_mlength),
    .o_data_valid  (o_mdata_valid),
    .o_data        (o_mdata),
    .o_data_last   (o_mdata_last)
  );

endmodule

// ==== tests/tb_packer_model.svh ====
// reference model for the packer testbench, holds accepted input traffic in order
// included inside the testbench module after the package import
`ifndef TB_PACKER_MODEL_SVH
`define TB_PACKER_MODEL_SVH

localparam int EXP_W = CMD_W + ADDR_W + LEN_W;

logic [EXP_W-1:0]  cmd_q  [$]; // {kind, addr, len} as accepted
logic [DATA_W-1:0] data_q [$];
logic [LEN_W-1:0]  wlen_q [$]; // length field of each accepted write
int                beat_idx = 0;

// next expected output, a command or a {data, last} beat
function automatic logic [EXP_W-1:0] expected_next(input bit beat);
  logic [DATA_W-1:0] data;
  logic              last;
  if (!beat) begin
    return cmd_q.pop_front();
  end
  data = data_q.pop_front();
  last = (beat_idx == int'(wlen_q[0])); // last sits on beat length plus one
  if (last) begin
    beat_idx = 0;
    void'(wlen_q.pop_front());
  end else begin
    beat_idx++;
  end
  return EXP_W'({data, last});
endfunction

task automatic check_cmd(input string name, input logic [CMD_W-1:0] exp_cmd,
                         input logic [ADDR_W-1:0] exp_addr, input logic [LEN_W-1:0] exp_len,
                         input logic [CMD_W-1:0] act_cmd, input logic [ADDR_W-1:0] act_addr,
                         input logic [LEN_W-1:0] act_len);
  if (act_cmd !== exp_cmd || act_addr !== exp_addr || act_len !== exp_len) begin
    $display("ERROR %s: command expected kind %0d addr %h len %0d, actual kind %0d addr %h len %0d",
             name, exp_cmd, exp_addr, exp_len, act_cmd, act_addr, act_len);
    stop_with_failure();
  end
endtask

task automatic check_beat(input string name, input logic [DATA_W-1:0] exp_data,
                          input logic exp_last, input logic [DATA_W-1:0] act_data,
                          input logic act_last);
  if (act_data !== exp_data || act_last !== exp_last) begin
    $display("ERROR %s: beat expected data %h last %0b, actual data %h last %0b",
             name, exp_data, exp_last, act_data, act_last);
    stop_with_failure();
  end
endtask

task automatic check_flags(input string name, input string what,
                           input logic [1:0] exp_flags, input logic [1:0] act_flags);
  if (act_flags !== exp_flags) begin
    $display("ERROR %s: %s expected %b actual %b", name, what, exp_flags, act_flags);
    stop_with_failure();
  end
endtask

`endif

// ==== tests/tb_corebus_packer.sv ====
// testbench for the write-packing stage, random traffic checked against a queue model
// compile with tb.f and run tb_corebus_packer as the top module
`timescale 1ns/1ps
module tb_corebus_packer;
  import corebus_pkg::*;

  localparam int COMMAND_DEPTH = 4;
  localparam int DATA_DEPTH    = MAX_BURST;
  localparam int N_MIXED       = 40;
  localparam int N_PACK        = 12;
  localparam int N_PRESSURE    = 30;
  localparam int N_AFTER_CLEAR = 10;
  localparam int N_TXN         = N_MIXED + N_PACK + N_PRESSURE + N_AFTER_CLEAR
                                 + COMMAND_DEPTH + 3;
  localparam int ACC_LOW       = 0;
  localparam int ACC_HIGH      = 1;
  localparam int ACC_RANDOM    = 2;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_clear;
  logic [1:0]        o_fifo_empty;
  logic [1:0]        o_fifo_full;
  logic              i_mcmd_valid;
  logic [CMD_W-1:0]  i_mcmd;
  logic [ADDR_W-1:0] i_maddr;
  logic [LEN_W-1:0]  i_mlength;
  logic              o_scmd_accept;
  logic              i_mdata_valid;
  logic [DATA_W-1:0] i_mdata;
  logic              i_mdata_last;
  logic              o_sdata_accept;
  logic              o_mcmd_valid;
  logic [CMD_W-1:0]  o_mcmd;
  logic [ADDR_W-1:0] o_maddr;
  logic [LEN_W-1:0]  o_mlength;
  logic              i_scmd_accept;
  logic              o_mdata_valid;
  logic [DATA_W-1:0] o_mdata;
  logic              o_mdata_last;
  logic              i_sdata_accept;

  int    seed        = 32'h384;
  int    accept_seed = 32'h384;
  int    accept_mode = ACC_LOW;
  string test_name   = "reset";
  int    lasts_in    = 0; // packets fully accepted at the input
  int    writes_out  = 0;
  bit    pack_check  = 1'b0;
  bit    burst_open  = 1'b0;

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  `include "tb_packer_model.svh"

  corebus_packer #(
    .COMMAND_DEPTH (COMMAND_DEPTH),
    .DATA_DEPTH    (DATA_DEPTH)
  ) corebus_packer_inst (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .o_fifo_empty   (o_fifo_empty),
    .o_fifo_full    (o_fifo_full),
    .i_mcmd_valid   (i_mcmd_valid),
    .i_mcmd         (i_mcmd),
    .i_maddr        (i_maddr),
    .i_mlength      (i_mlength),
    .o_scmd_accept  (o_scmd_accept),
    .i_mdata_valid  (i_mdata_valid),
    .i_mdata        (i_mdata),
    .i_mdata_last   (i_mdata_last),
    .o_sdata_accept (o_sdata_accept),
    .o_mcmd_valid   (o_mcmd_valid),
    .o_mcmd         (o_mcmd),
    .o_maddr        (o_maddr),
    .o_mlength      (o_mlength),
    .i_scmd_accept  (i_scmd_accept),
    .o_mdata_valid  (o_mdata_valid),
    .o_mdata        (o_mdata),
    .o_mdata_last   (o_mdata_last),
    .i_sdata_accept (i_sdata_accept)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // master side accepts
  always @(negedge i_clk) begin
    case (accept_mode)
      ACC_HIGH: begin
        i_scmd_accept  = 1'b1;
        i_sdata_accept = 1'b1;
      end
      ACC_RANDOM: begin
        i_scmd_accept  = ($random(accept_seed) & 3) != 0; // three in four cycles
        i_sdata_accept = ($random(accept_seed) & 3) != 0;
      end
      default: begin
        i_scmd_accept  = 1'b0;
        i_sdata_accept = 1'b0;
      end
    endcase
  end

  // input monitor feeds the model
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if (i_mcmd_valid && o_scmd_accept) begin
        cmd_q.push_back({i_mcmd, i_maddr, i_mlength});
        if (i_mcmd == CMD_WRITE) begin
          wlen_q.push_back(i_mlength);
        end
      end
      if (i_mdata_valid && o_sdata_accept) begin
        data_q.push_back(i_mdata);
        if (i_mdata_last) begin
          lasts_in <= lasts_in + 1; // seen by the compare process one edge later
        end
      end
    end
  end

  always @(posedge i_clk) begin : compare
    logic [EXP_W-1:0] exp;
    if (i_rst_n) begin
      if (o_mcmd_valid && o_mcmd == CMD_WRITE && writes_out >= lasts_in) begin
        $display("in %s a write command was valid before its last beat was stored", test_name);
        stop_with_failure();
      end
      if (o_mcmd_valid && i_scmd_accept) begin
        if (cmd_q.size() == 0) begin
          $display("in %s a command left the packer that was never sent", test_name);
          stop_with_failure();
        end
        exp = expected_next(1'b0);
        check_cmd(test_name, exp[EXP_W-1 -: CMD_W], exp[LEN_W +: ADDR_W], exp[LEN_W-1:0],
                  o_mcmd, o_maddr, o_mlength);
        if (o_mcmd == CMD_WRITE) begin
          writes_out++;
        end
      end
      if (pack_check && burst_open && !o_mdata_valid) begin
        $display("in %s a write burst had a gap between its beats", test_name);
        stop_with_failure();
      end
      if (o_mdata_valid && i_sdata_accept) begin
        if (data_q.size() == 0 || wlen_q.size() == 0) begin
          $display("in %s a data beat left with no matching write", test_name);
          stop_with_failure();
        end
        exp = expected_next(1'b1);
        check_beat(test_name, exp[DATA_W:1], exp[0], o_mdata, o_mdata_last);
        burst_open = !o_mdata_last;
      end
    end
  end

  task automatic send_cmd(input logic [CMD_W-1:0] kind, input logic [ADDR_W-1:0] addr,
                          input logic [LEN_W-1:0] len);
    bit taken;
    i_mcmd_valid = 1'b1;
    i_mcmd       = kind;
    i_maddr      = addr;
    i_mlength    = len;
    taken        = 1'b0;
    while (!taken) begin
      taken = o_scmd_accept; // flop based, holds until the rising edge
      @(negedge i_clk);
    end
    i_mcmd_valid = 1'b0;
  endtask

  task automatic send_beat(input logic [DATA_W-1:0] data, input logic last);
    bit taken;
    i_mdata_valid = 1'b1;
    i_mdata       = data;
    i_mdata_last  = last;
    taken         = 1'b0;
    while (!taken) begin
      taken = o_sdata_accept;
      @(negedge i_clk);
    end
    i_mdata_valid = 1'b0;
  endtask

  task automatic send_beats(input logic [LEN_W-1:0] len);
    for (int i = 0; i <= int'(len); i++) begin
      send_beat($random(seed), i == int'(len));
    end
  endtask

  // order 0 command first, 1 data first, else both together
  task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                            input int order);
    if (order == 0) begin
      send_cmd(CMD_WRITE, addr, len);
      send_beats(len);
    end else if (order == 1) begin
      send_beats(len);
      send_cmd(CMD_WRITE, addr, len);
    end else begin
      fork
        send_cmd(CMD_WRITE, addr, len);
        send_beats(len);
      join
    end
  endtask

  task automatic run_mixed(input int n);
    int                kind_sel;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    for (int i = 0; i < n; i++) begin
      kind_sel = $unsigned($random(seed)) % 3;
      addr     = $random(seed);
      len      = LEN_W'($random(seed));
      case (kind_sel)
        0:       send_cmd(CMD_READ, addr, len);
        1:       send_cmd(CMD_FLUSH, addr, len);
        default: send_write(addr, len, $unsigned($random(seed)) % 3);
      endcase
    end
  endtask

  task automatic run_packing(input int n);
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    for (int i = 0; i < n; i++) begin
      addr = $random(seed);
      len  = LEN_W'($random(seed));
      send_write(addr, len, i % 3);
      if (i % 4 == 3) begin
        send_cmd(CMD_READ, addr, '0); // reads wait behind the write
      end
    end
  endtask

  // waits until every accepted item has left, the watchdog bounds it
  task automatic wait_drain();
    while (cmd_q.size() != 0 || data_q.size() != 0) begin
      @(negedge i_clk);
    end
    @(negedge i_clk);
    check_flags(test_name, "o_fifo_empty after drain", 2'b11, o_fifo_empty);
  endtask

  initial begin : watchdog
    repeat (N_TXN * 50 + 500) @(posedge i_clk);
    $display("watchdog expired, the test sequence did not finish in time");
    stop_with_failure();
  end

  initial begin : test_sequence
    i_rst_n        = 1'b0;
    i_clear        = 1'b0;
    i_mcmd_valid   = 1'b0;
    i_mcmd         = '0;
    i_maddr        = '0;
    i_mlength      = '0;
    i_mdata_valid  = 1'b0;
    i_mdata        = '0;
    i_mdata_last   = 1'b0;
    i_scmd_accept  = 1'b0;
    i_sdata_accept = 1'b0;
    repeat (10) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_flags(test_name, "o_fifo_empty", 2'b11, o_fifo_empty);
    check_flags(test_name, "o_fifo_full", 2'b00, o_fifo_full);
    if (o_mcmd_valid || o_mdata_valid || !o_scmd_accept || !o_sdata_accept) begin
      $display("valid or accept outputs have the wrong level after reset");
      stop_with_failure();
    end

    test_name   = "mixed order";
    accept_mode = ACC_RANDOM;
    run_mixed(N_MIXED);
    wait_drain();

    test_name   = "packing";
    accept_mode = ACC_HIGH;
    repeat (2) @(negedge i_clk);
    pack_check = 1'b1;
    run_packing(N_PACK);
    wait_drain();
    pack_check = 1'b0;

    test_name   = "back-pressure";
    accept_mode = ACC_RANDOM;
    run_mixed(N_PRESSURE);
    wait_drain();

    // slicer takes two flushes, the command FIFO the rest
    test_name   = "fifo fill";
    accept_mode = ACC_LOW;
    repeat (2) @(negedge i_clk);
    for (int i = 0; i < COMMAND_DEPTH + 2; i++) begin
      send_cmd(CMD_FLUSH, ADDR_W'(i), '0);
    end
    repeat (3) @(negedge i_clk);
    check_flags(test_name, "o_fifo_full", 2'b01, o_fifo_full);
    if (o_scmd_accept) begin
      $display("command input still accepts with the command FIFO full");
      stop_with_failure();
    end
    accept_mode = ACC_HIGH;
    wait_drain();

    // incomplete write parks in both FIFOs
    test_name = "clear";
    send_cmd(CMD_WRITE, 32'h0000_1000, 4'd3);
    send_beat(32'hdead_0001, 1'b0);
    send_beat(32'hdead_0002, 1'b0);
    repeat (2) @(negedge i_clk);
    check_flags(test_name, "o_fifo_empty before clear", 2'b00, o_fifo_empty);
    i_clear = 1'b1;
    @(negedge i_clk);
    i_clear = 1'b0;
    check_flags(test_name, "o_fifo_empty after clear", 2'b11, o_fifo_empty);
    cmd_q.delete();
    data_q.delete();
    wlen_q.delete();
    beat_idx = 0;

    test_name   = "after clear";
    accept_mode = ACC_RANDOM;
    run_mixed(N_AFTER_CLEAR);
    wait_drain();

    if (cmd_q.size() != 0 || data_q.size() != 0 || wlen_q.size() != 0) begin
      $display("the model still holds traffic that never left the packer");
      stop_with_failure();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
+incdir+tests
common/corebus_pkg.sv
logic/command_fifo.sv
logic/write_data_fifo.sv
logic/request_slicer.sv
packer/packer_control.sv
packer/corebus_packer.sv
tests/tb_corebus_packer.sv
